// File: hw/ntm_math_pkg.sv
// Shared widths, register map and types of the modular summation peripheral
// Operands are residues below the modulus; AXI4-Lite responses are always OKAY
`default_nettype none

package ntm_math_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Operands, modulus, length and AXI data share one width
  localparam int DATA_SIZE = 32;
  localparam int ADDR_SIZE = 8;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [ADDR_SIZE-1:0] REG_CTRL   = 8'h00;
  localparam logic [ADDR_SIZE-1:0] REG_MODULO = 8'h04;
  localparam logic [ADDR_SIZE-1:0] REG_LENGTH = 8'h08;
  localparam logic [ADDR_SIZE-1:0] REG_DATA   = 8'h0C;
  localparam logic [ADDR_SIZE-1:0] REG_STATUS = 8'h10;
  localparam logic [ADDR_SIZE-1:0] REG_RESULT = 8'h14;

  // Only response code ever returned
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Master to slave signals of the AXI4-Lite port
  typedef struct packed {
    logic                 awvalid;
    logic [ADDR_SIZE-1:0] awaddr;
    logic                 wvalid;
    logic [DATA_SIZE-1:0] wdata;
    logic                 bready;
    logic                 arvalid;
    logic [ADDR_SIZE-1:0] araddr;
    logic                 rready;
  } axil_req_t;

  // Slave to master signals of the AXI4-Lite port
  typedef struct packed {
    logic                 awready;
    logic                 wready;
    logic                 bvalid;
    logic [1:0]           bresp;
    logic                 arready;
    logic                 rvalid;
    logic [DATA_SIZE-1:0] rdata;
    logic [1:0]           rresp;
  } axil_rsp_t;

  // Adder input, both data fields below modulo
  typedef struct packed {
    logic [DATA_SIZE-1:0] modulo;
    logic [DATA_SIZE-1:0] data_a;
    logic [DATA_SIZE-1:0] data_b;
  } scalar_operands_t;

  // Controller FSM
  typedef enum logic [1:0] {
    STARTER = 2'd0,
    INPUT   = 2'd1,
    ENDER   = 2'd2
  } summation_state_t;

endpackage

`default_nettype wire

// File: hw/ntm_scalar_adder.sv
// Two-stage modular adder with the result valid exactly 2 cycles after start
// Both data operands must be below the modulus for a single subtraction to suffice
`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_adder (
  input  logic                                 CLK,
  input  logic                                 RST,
  input  logic                                 start,
  input  ntm_math_pkg::scalar_operands_t       operands,
  output logic                                 ready,
  output logic [ntm_math_pkg::DATA_SIZE-1:0]   result
);

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Stage 1 raw sum with carry in the top bit
  logic                 valid_s1;
  logic [DATA_SIZE:0]   sum_s1;
  logic [DATA_SIZE-1:0] modulo_s1;

  // Reduction terms seen by stage 2
  logic [DATA_SIZE-1:0] reduced_s1;
  logic                 wrap_s1;

  //////////////////////////////////////////////////////////////////////
  // Stage 1
  //////////////////////////////////////////////////////////////////////

  // Valid bit follows the data so back to back starts are fine
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= start;
    end
  end

  // Extended by one bit so a sum past 2^DATA_SIZE stays exact
  always_ff @(posedge CLK) begin
    if (start) begin
      sum_s1    <= {1'b0, operands.data_a} + {1'b0, operands.data_b};
      modulo_s1 <= operands.modulo;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2
  //////////////////////////////////////////////////////////////////////

  // Sum is below 2*modulo so one conditional subtraction reduces it
  assign wrap_s1    = (sum_s1 >= {1'b0, modulo_s1});
  assign reduced_s1 = sum_s1[DATA_SIZE-1:0] - modulo_s1;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready <= 1'b0;
    end else begin
      ready <= valid_s1;
    end
  end

  // Reduced value always fits the data width
  always_ff @(posedge CLK) begin
    if (valid_s1) begin
      if (wrap_s1) begin
        result <= reduced_s1;
      end else begin
        result <= sum_s1[DATA_SIZE-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ntm_scalar_summation_function.sv
// Accumulates LENGTH words modulo MODULO one word at a time through the adder
// The accumulator restarts at zero on each start and a start while busy is ignored
`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_summation_function (
  input  logic                                 CLK,
  input  logic                                 RST,
  // Host side
  input  logic                                 start,
  input  logic [ntm_math_pkg::DATA_SIZE-1:0]   modulo,
  input  logic [ntm_math_pkg::DATA_SIZE-1:0]   length,
  input  logic [ntm_math_pkg::DATA_SIZE-1:0]   data_in,
  input  logic                                 data_valid,
  output logic                                 in_ready,
  output logic                                 busy,
  output logic [ntm_math_pkg::DATA_SIZE-1:0]   data_out,
  output logic                                 data_out_valid,
  output logic                                 done,
  // Adder side
  input  logic [ntm_math_pkg::DATA_SIZE-1:0]   adder_result,
  input  logic                                 adder_ready,
  output ntm_math_pkg::scalar_operands_t       adder_operands,
  output logic                                 adder_start
);

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  summation_state_t     state_q;

  // Words already accumulated in this run
  logic [DATA_SIZE-1:0] index_q;
  logic [DATA_SIZE-1:0] index_next;
  logic                 last_word;

  // Running sum that is also the second adder operand
  logic [DATA_SIZE-1:0] acc_q;

  //////////////////////////////////////////////////////////////////////
  // Status and compare
  //////////////////////////////////////////////////////////////////////

  assign in_ready = (state_q == INPUT);
  assign busy     = (state_q != STARTER);
  assign data_out = acc_q;

  // Length is nonzero whenever this is looked at
  assign index_next = index_q + DATA_SIZE'(1);
  assign last_word  = (index_next == length);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q        <= STARTER;
      index_q        <= '0;
      data_out_valid <= 1'b0;
      done           <= 1'b0;
      adder_start    <= 1'b0;
    end else begin
      // Single cycle pulses by default
      data_out_valid <= 1'b0;
      done           <= 1'b0;
      adder_start    <= 1'b0;
      case (state_q)
        STARTER: begin
          if (start) begin
            index_q <= '0;
            // Empty run finishes at once with sum zero
            if (length == '0) begin
              done <= 1'b1;
            end else begin
              state_q <= INPUT;
            end
          end
        end
        INPUT: begin
          if (data_valid) begin
            adder_start <= 1'b1;
            state_q     <= ENDER;
          end
        end
        ENDER: begin
          // Wait out the adder pipeline
          if (adder_ready) begin
            data_out_valid <= 1'b1;
            if (last_word) begin
              done    <= 1'b1;
              state_q <= STARTER;
            end else begin
              index_q <= index_next;
              state_q <= INPUT;
            end
          end
        end
        default: begin
          state_q <= STARTER;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if ((state_q == STARTER) && start) begin
      acc_q <= '0;
    end else if ((state_q == ENDER) && adder_ready) begin
      acc_q <= adder_result;
    end
    // New word plus current sum
    if ((state_q == INPUT) && data_valid) begin
      adder_operands.modulo <= modulo;
      adder_operands.data_a <= data_in;
      adder_operands.data_b <= acc_q;
    end
  end

endmodule

`default_nettype wire

// File: hw/ntm_summation_regs.sv
// AXI4-Lite slave of the summation peripheral, whole-word writes, OKAY responses only
// DATA writes stall while a run waits on the adder and are dropped while idle
`timescale 1ns/1ps
`default_nettype none

module ntm_summation_regs (
  input  logic                                 CLK,
  input  logic                                 RST,
  input  ntm_math_pkg::axil_req_t              axil_req,
  output ntm_math_pkg::axil_rsp_t              axil_rsp,
  // Controller side
  output logic                                 start,
  output logic [ntm_math_pkg::DATA_SIZE-1:0]   modulo,
  output logic [ntm_math_pkg::DATA_SIZE-1:0]   length,
  output logic [ntm_math_pkg::DATA_SIZE-1:0]   data_in,
  output logic                                 data_valid,
  input  logic                                 in_ready,
  input  logic                                 busy,
  input  logic [ntm_math_pkg::DATA_SIZE-1:0]   sum_value,
  input  logic                                 sum_valid,
  input  logic                                 done
);

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Write channel
  logic                 wr_is_data;
  logic                 wr_stall;
  logic                 wr_accept;
  logic                 bvalid_q;

  // Read channel
  logic                 rd_accept;
  logic                 rvalid_q;
  logic [DATA_SIZE-1:0] rdata_q;
  logic [DATA_SIZE-1:0] rd_value;

  // Result and sticky done
  logic [DATA_SIZE-1:0] result_q;
  logic                 done_q;

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  assign wr_is_data = (axil_req.awaddr == REG_DATA);

  // Back-pressure on DATA until the controller can take a word
  assign wr_stall  = wr_is_data && busy && !in_ready;

  // Address and data always taken in the same cycle
  assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q && !wr_stall;

  // One read outstanding at a time
  assign rd_accept = axil_req.arvalid && !rvalid_q;

  always_comb begin
    axil_rsp.awready = wr_accept;
    axil_rsp.wready  = wr_accept;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = AXI_RESP_OKAY;
    axil_rsp.arready = rd_accept;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = AXI_RESP_OKAY;
  end

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bvalid_q   <= 1'b0;
      start      <= 1'b0;
      data_valid <= 1'b0;
      modulo     <= '0;
      length     <= '0;
    end else begin
      start      <= 1'b0;
      data_valid <= 1'b0;
      // Response held until the host takes it
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (wr_accept) begin
        case (axil_req.awaddr)
          REG_CTRL: begin
            // Not forwarded while busy so the running sum survives
            start <= axil_req.wdata[0] && !busy;
          end
          REG_MODULO: begin
            modulo <= axil_req.wdata;
          end
          REG_LENGTH: begin
            length <= axil_req.wdata;
          end
          REG_DATA: begin
            // Idle writes are accepted and thrown away
            data_valid <= busy;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Word pushed to the controller
  always_ff @(posedge CLK) begin
    if (wr_accept && wr_is_data) begin
      data_in <= axil_req.wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result and done
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result_q <= '0;
      done_q   <= 1'b0;
    end else begin
      // Start and a controller update never coincide
      if (start) begin
        result_q <= '0;
      end else if (sum_valid) begin
        result_q <= sum_value;
      end
      if (start) begin
        done_q <= 1'b0;
      end else if (done) begin
        done_q <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  // DATA and unmapped offsets read as zero
  always_comb begin
    case (axil_req.araddr)
      REG_MODULO: rd_value = modulo;
      REG_LENGTH: rd_value = length;
      REG_STATUS: rd_value = {{(DATA_SIZE-3){1'b0}}, in_ready, done_q, busy};
      REG_RESULT: rd_value = result_q;
      default:    rd_value = '0;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      if (rd_accept) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_value;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ntm_summation_top.sv
// Modular summation peripheral behind an AXI4-Lite slave
// Register map and operand limits as in the shared package
`timescale 1ns/1ps
`default_nettype none

module ntm_summation_top (
  input  logic                     CLK,
  input  logic                     RST,
  input  ntm_math_pkg::axil_req_t  axil_req,
  output ntm_math_pkg::axil_rsp_t  axil_rsp
);

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Register block to controller
  logic                 start;
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] length;
  logic [DATA_SIZE-1:0] data_in;
  logic                 data_valid;

  // Controller back to register block
  logic                 in_ready;
  logic                 busy;
  logic [DATA_SIZE-1:0] sum_value;
  logic                 sum_valid;
  logic                 done;

  // Controller and adder
  scalar_operands_t     adder_operands;
  logic                 adder_start;
  logic [DATA_SIZE-1:0] adder_result;
  logic                 adder_ready;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  ntm_summation_regs u_regs (
    .CLK        (CLK),
    .RST        (RST),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .start      (start),
    .modulo     (modulo),
    .length     (length),
    .data_in    (data_in),
    .data_valid (data_valid),
    .in_ready   (in_ready),
    .busy       (busy),
    .sum_value  (sum_value),
    .sum_valid  (sum_valid),
    .done       (done)
  );

  ntm_scalar_summation_function u_summation (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .modulo         (modulo),
    .length         (length),
    .data_in        (data_in),
    .data_valid     (data_valid),
    .in_ready       (in_ready),
    .busy           (busy),
    .data_out       (sum_value),
    .data_out_valid (sum_valid),
    .done           (done),
    .adder_result   (adder_result),
    .adder_ready    (adder_ready),
    .adder_operands (adder_operands),
    .adder_start    (adder_start)
  );

  ntm_scalar_adder u_adder (
    .CLK      (CLK),
    .RST      (RST),
    .start    (adder_start),
    .operands (adder_operands),
    .ready    (adder_ready),
    .result   (adder_result)
  );

endmodule

`default_nettype wire

// File: dv/tb_ntm_summation.sv
// Drives the modular summation peripheral only through its AXI4-Lite port
// Moduli and words come from an xorshift seeded with 17 and sums from a 64-bit model
`timescale 1ns/1ps
`default_nettype none

module tb_ntm_summation;

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Run limits
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_RUNS        = 30;
  localparam int MAX_LEN         = 12;
  // 40 cycles per word is well above the cost of one checked word
  localparam int WATCHDOG_CYCLES = NUM_RUNS * MAX_LEN * 40 + 4000;

  // STATUS bits
  localparam logic [DATA_SIZE-1:0] BUSY_BIT     = 32'h1;
  localparam logic [DATA_SIZE-1:0] DONE_BIT     = 32'h2;
  localparam logic [DATA_SIZE-1:0] IN_READY_BIT = 32'h4;

  logic        CLK = 1'b0;
  logic        RST;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;

  logic [31:0] rng_state   = 32'd17;
  int          error_count = 0;
  int          check_count = 0;

  ntm_summation_top dut (
    .CLK      (CLK),
    .RST      (RST),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  // 20 ns period
  always #10 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // 32-bit xorshift with shifts 13 17 5
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_equal(input string what, input logic [DATA_SIZE-1:0] got,
                             input logic [DATA_SIZE-1:0] expected);
    check_count++;
    assert (got === expected) else begin
      error_count++;
      $display("error at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, expected);
    end
  endtask

  // Address and data go out together on the falling edge
  task automatic axil_write(input logic [ADDR_SIZE-1:0] addr, input logic [DATA_SIZE-1:0] data);
    @(negedge CLK);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    @(posedge CLK);
    while (!axil_rsp.awready) @(posedge CLK);
    check_equal("WREADY with AWREADY", {31'd0, axil_rsp.wready}, 32'd1);
    @(negedge CLK);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    @(posedge CLK);
    while (!axil_rsp.bvalid) @(posedge CLK);
    // OKAY is the only response
    check_equal("BRESP", {30'd0, axil_rsp.bresp}, 32'd0);
    @(negedge CLK);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [ADDR_SIZE-1:0] addr, output logic [DATA_SIZE-1:0] data);
    @(negedge CLK);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    @(posedge CLK);
    while (!axil_rsp.arready) @(posedge CLK);
    @(negedge CLK);
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    @(posedge CLK);
    while (!axil_rsp.rvalid) @(posedge CLK);
    data = axil_rsp.rdata;
    check_equal("RRESP", {30'd0, axil_rsp.rresp}, 32'd0);
    @(negedge CLK);
    axil_req.rready = 1'b0;
  endtask

  // Poll STATUS until any bit of the mask is set
  task automatic wait_status(input logic [DATA_SIZE-1:0] mask);
    logic [DATA_SIZE-1:0] status;
    status = '0;
    while ((status & mask) == '0) begin
      axil_read(REG_STATUS, status);
    end
  endtask

  // One run checked word by word or pushed back to back against the stall
  task automatic run_sum(input logic [DATA_SIZE-1:0] modulo, input logic [DATA_SIZE-1:0] length,
                         input bit per_word, input bit restart_mid);
    logic [DATA_SIZE-1:0] word;
    logic [DATA_SIZE-1:0] value;
    logic [63:0]          model_sum;
    int unsigned          idx;
    model_sum = '0;
    axil_write(REG_MODULO, modulo);
    axil_write(REG_LENGTH, length);
    axil_write(REG_CTRL, 32'h1);
    if (length != '0) begin
      // New start drops the sticky done bit
      axil_read(REG_STATUS, value);
      check_equal("STATUS busy after start", value & BUSY_BIT, BUSY_BIT);
      check_equal("STATUS done after start", value & DONE_BIT, '0);
    end
    for (idx = 0; idx < length; idx++) begin
      word      = next_random() % modulo;
      model_sum = (model_sum + {32'd0, word}) % {32'd0, modulo};
      axil_write(REG_DATA, word);
      // Second start in the middle of a run must leave the sum alone
      if (restart_mid && idx == 0) begin
        axil_write(REG_CTRL, 32'h1);
      end
      if (per_word) begin
        // Partial sum is in RESULT once the FSM waits again or is done
        wait_status(IN_READY_BIT | DONE_BIT);
        axil_read(REG_RESULT, value);
        check_equal("partial RESULT", value, model_sum[DATA_SIZE-1:0]);
      end
    end
    wait_status(DONE_BIT);
    axil_read(REG_STATUS, value);
    check_equal("STATUS busy after run", value & BUSY_BIT, '0);
    check_equal("STATUS done after run", value & DONE_BIT, DONE_BIT);
    axil_read(REG_RESULT, value);
    check_equal("final RESULT", value, model_sum[DATA_SIZE-1:0]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [DATA_SIZE-1:0] value;
    logic [DATA_SIZE-1:0] held;
    logic [DATA_SIZE-1:0] modulo;
    logic [DATA_SIZE-1:0] length;
    int                   run;
    axil_req = '0;
    RST      = 1'b1;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Configuration reads back while DATA and holes read as zero
    axil_write(REG_MODULO, 32'h1234_5677);
    axil_write(REG_LENGTH, 32'd7);
    axil_read(REG_MODULO, value);
    check_equal("MODULO read back", value, 32'h1234_5677);
    axil_read(REG_LENGTH, value);
    check_equal("LENGTH read back", value, 32'd7);
    axil_read(REG_DATA, value);
    check_equal("DATA read", value, '0);
    axil_read(8'h18, value);
    check_equal("unmapped read 0x18", value, '0);
    axil_read(8'hFC, value);
    check_equal("unmapped read 0xFC", value, '0);

    // Modulus 1 where every word is 0
    run_sum(32'd1, 32'd5, 1'b1, 1'b0);

    // Every third modulus sits just under 2^32 so the carry path is hit
    for (run = 0; run < NUM_RUNS; run++) begin
      case (run % 3)
        0:       modulo = 32'hFFFF_FFFF - (next_random() & 32'h0000_FFFF);
        1:       modulo = (next_random() % 32'd1000) + 32'd1;
        default: modulo = next_random() | 32'h1;
      endcase
      length = (next_random() % MAX_LEN) + 1;
      run_sum(modulo, length, (run % 2) == 0, 1'b0);
    end

    // DATA while idle is thrown away
    axil_read(REG_RESULT, held);
    axil_write(REG_DATA, 32'd5);
    axil_read(REG_RESULT, value);
    check_equal("RESULT after idle DATA", value, held);

    // Empty run on top of the sum left by the random runs
    run_sum(32'd13, 32'd0, 1'b1, 1'b0);

    // Start while busy ignored
    run_sum(32'd1000003, 32'd6, 1'b1, 1'b1);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout after %0d cycles, the DUT stopped answering on AXI4-Lite", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
hw/ntm_math_pkg.sv
hw/ntm_scalar_adder.sv
hw/ntm_scalar_summation_function.sv
hw/ntm_summation_regs.sv
hw/ntm_summation_top.sv
dv/tb_ntm_summation.sv

// File: Makefile
# Verilator build and run of the modular summation testbench
# Any variable below can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= tb_ntm_summation
RTL_TOP    ?= ntm_summation_top
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES  ?= hw/ntm_math_pkg.sv hw/ntm_scalar_adder.sv \
              hw/ntm_scalar_summation_function.sv hw/ntm_summation_regs.sv \
              hw/ntm_summation_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
